// ==== icache_data_bank.sv ====
// one icache data bank, a 64-entry single-port synchronous RAM, one instance per way
module icache_data_bank (
  input  logic                               clk_i,
  input  icache_pkg::bank_addr_t             addr_i,
  input  logic                               we_i,
  input  logic [icache_pkg::bank_width-1:0]  wdata_i,
  output logic [icache_pkg::bank_width-1:0]  rdata_o
);

  logic [icache_pkg::bank_width-1:0] mem [icache_pkg::num_sets*icache_pkg::num_ways];

  // a write cycle leaves the previous read word on rdata_o
  always_ff @(posedge clk_i) begin
    if (we_i) begin
      mem[addr_i] <= wdata_i;
    end else begin
      rdata_o <= mem[addr_i];
    end
  end

  // write enable comes from fetch and fill handshakes upstream
  assert property (@(posedge clk_i) !$isunknown(we_i))
    else $error("data bank write enable is unknown");

endmodule

// ==== icache_fill_steer.sv ====
// icache bank address and write steering: fetch reads all banks, fills rotate the block by way
module icache_fill_steer (
  input  logic                                   fetch_v_i,
  input  icache_pkg::bank_addr_t                 fetch_addr_i,
  input  logic                                   data_pkt_v_i,
  input  icache_pkg::data_pkt_s                  data_pkt_i,
  output icache_pkg::bank_addr_t [icache_pkg::num_ways-1:0] bank_addr_o,
  output logic [icache_pkg::num_ways-1:0]        bank_we_o,
  output logic [icache_pkg::num_ways-1:0][icache_pkg::bank_width-1:0] bank_wdata_o
);

  logic [icache_pkg::num_ways-1:0][icache_pkg::bank_width-1:0] block_words;

  assign block_words = data_pkt_i.data;

  for (genvar b = 0; b < icache_pkg::num_ways; b++) begin : g_steer
    logic [icache_pkg::way_bits-1:0] slot;

    // bank b holds word (b ^ way) of the block, stored at word slot (b ^ way)
    assign slot = data_pkt_i.way_id ^ (icache_pkg::way_bits)'(b);

    assign bank_addr_o[b] = fetch_v_i ? fetch_addr_i : {data_pkt_i.index, slot};
    assign bank_we_o[b] = data_pkt_v_i & ~fetch_v_i;
    assign bank_wdata_o[b] = block_words[slot];
  end

endmodule

// ==== icache_lru.sv ====
// icache tree pseudo-LRU per set, updated on TV hits, giving the replacement way on a miss
module icache_lru (
  input  logic                                   clk_i,
  input  logic                                   reset_i,
  input  logic                                   update_v_i,
  input  logic [icache_pkg::index_bits-1:0]      index_i,
  input  logic [icache_pkg::way_bits-1:0]        hit_way_i,
  input  logic [icache_pkg::num_ways-1:0]        valid_ways_i,
  output logic [icache_pkg::way_bits-1:0]        repl_way_o
);

  // bit 0 root, bit 1 ways 0/1, bit 2 ways 2/3
  logic [icache_pkg::num_ways-2:0] tree_r [icache_pkg::num_sets];
  logic [icache_pkg::num_ways-2:0] tree;

  assign tree = tree_r[index_i];

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      for (int s = 0; s < icache_pkg::num_sets; s++) begin
        tree_r[s] <= '0;
      end
    end else if (update_v_i) begin
      // point away from the way just used
      tree_r[index_i][0] <= ~hit_way_i[1];
      if (hit_way_i[1]) begin
        tree_r[index_i][2] <= ~hit_way_i[0];
      end else begin
        tree_r[index_i][1] <= ~hit_way_i[0];
      end
    end
  end

  // invalid ways first, lowest one
  always_comb begin
    repl_way_o = {tree[0], tree[0] ? tree[2] : tree[1]};
    for (int w = icache_pkg::num_ways - 1; w >= 0; w--) begin
      if (!valid_ways_i[w]) begin
        repl_way_o = (icache_pkg::way_bits)'(w);
      end
    end
  end

endmodule

// ==== icache_pkg.sv ====
// shared geometry, encodings and packet formats for the icache; referenced by scoped names
package icache_pkg;

  // cache geometry
  localparam int num_ways = 4;
  localparam int num_sets = 16;
  localparam int way_bits = 2;
  localparam int index_bits = 4;
  localparam int word_bits = 2;
  localparam int byte_bits = 3;

  localparam int bank_width = 64;
  localparam int block_width = 256;

  localparam int vaddr_width = 32;
  localparam int paddr_width = 32;
  localparam int page_offset_bits = 12;
  localparam int ptag_width = paddr_width - page_offset_bits;
  localparam int instr_width = 32;

  typedef enum logic [0:0] {
    coh_invalid = 1'b0,
    coh_shared  = 1'b1
  } coh_state_e;

  typedef enum logic [1:0] {
    tag_set_clear  = 2'd0,
    tag_invalidate = 2'd1,
    tag_set_tag    = 2'd2
  } tag_op_e;

  // only the miss load is issued by this cache
  typedef enum logic [0:0] {
    req_miss_load = 1'b0
  } req_type_e;

  // {index, word offset}
  typedef logic [index_bits+word_bits-1:0] bank_addr_t;

  typedef struct packed {
    coh_state_e             state;
    logic [ptag_width-1:0]  tag;
  } tag_entry_s;

  typedef struct packed {
    tag_op_e                op;
    logic [index_bits-1:0]  index;
    logic [way_bits-1:0]    way_id;
    logic [ptag_width-1:0]  tag;
    coh_state_e             state;
  } tag_pkt_s;

  // always a full block write
  typedef struct packed {
    logic [index_bits-1:0]   index;
    logic [way_bits-1:0]     way_id;
    logic [block_width-1:0]  data;
  } data_pkt_s;

  typedef struct packed {
    req_type_e               req_type;
    logic [paddr_width-1:0]  addr;
    logic [way_bits-1:0]     repl_way;
  } cache_req_s;

endpackage

// ==== icache_tag_array.sv ====
// icache tag and state storage per set and way, written by tag packets and read in TL
module icache_tag_array (
  input  logic                                   clk_i,
  input  logic                                   reset_i,
  input  logic                                   rd_v_i,
  input  logic [icache_pkg::index_bits-1:0]      rd_index_i,
  input  logic                                   tag_pkt_v_i,
  input  icache_pkg::tag_pkt_s                   tag_pkt_i,
  output icache_pkg::tag_entry_s [icache_pkg::num_ways-1:0] entries_o
);

  icache_pkg::tag_entry_s [icache_pkg::num_ways-1:0] mem [icache_pkg::num_sets];
  logic [icache_pkg::num_ways-1:0] way_hot;

  assign way_hot = (icache_pkg::num_ways)'(1) << tag_pkt_i.way_id;

  always_ff @(posedge clk_i) begin
    if (!reset_i && tag_pkt_v_i) begin
      for (int w = 0; w < icache_pkg::num_ways; w++) begin
        case (tag_pkt_i.op)
          icache_pkg::tag_set_clear: begin
            mem[tag_pkt_i.index][w] <= '0;
          end
          // tag kept, only the state drops
          icache_pkg::tag_invalidate: begin
            if (way_hot[w]) begin
              mem[tag_pkt_i.index][w].state <= icache_pkg::coh_invalid;
            end
          end
          icache_pkg::tag_set_tag: begin
            if (way_hot[w]) begin
              mem[tag_pkt_i.index][w] <= {tag_pkt_i.state, tag_pkt_i.tag};
            end
          end
          default: begin
          end
        endcase
      end
    end else if (rd_v_i) begin
      entries_o <= mem[rd_index_i];
    end
  end

  // fetch owns the array in a lookup cycle, so the top must hold packets off
  assert property (@(posedge clk_i) disable iff (reset_i) !(rd_v_i && tag_pkt_v_i))
    else $error("tag packet write collided with a lookup read");

endmodule

// ==== icache_top.sv ====
// icache top level holding the TL/TV fetch pipeline, the miss request and tracker, and the fill ports
module icache_top (
  input  logic                                   clk_i,
  input  logic                                   reset_i,

  input  logic [icache_pkg::vaddr_width-1:0]     vaddr_i,
  input  logic                                   vaddr_v_i,
  output logic                                   vaddr_ready_o,

  input  logic [icache_pkg::ptag_width-1:0]      ptag_i,
  input  logic                                   ptag_v_i,

  output logic [icache_pkg::instr_width-1:0]     data_o,
  output logic                                   data_v_o,
  output logic                                   miss_o,

  output icache_pkg::cache_req_s                 cache_req_o,
  output logic                                   cache_req_v_o,
  input  logic                                   cache_req_ready_i,
  input  logic                                   cache_req_complete_i,

  input  icache_pkg::tag_pkt_s                   tag_pkt_i,
  input  logic                                   tag_pkt_v_i,
  output logic                                   tag_pkt_ready_o,
  input  icache_pkg::data_pkt_s                  data_pkt_i,
  input  logic                                   data_pkt_v_i,
  output logic                                   data_pkt_ready_o
);

  logic tl_we;
  logic tv_we;
  logic tv_hold;
  logic miss_tv;
  logic hit_tv;
  logic v_tl_r;
  logic v_tv_r;
  logic miss_r;

  logic [icache_pkg::index_bits-1:0] vaddr_index;
  logic [icache_pkg::word_bits-1:0] vaddr_word;
  logic [icache_pkg::index_bits-1:0] index_tv;
  logic [icache_pkg::page_offset_bits-1:0] poff_tl_r;
  logic [icache_pkg::paddr_width-1:0] paddr_tv_r;

  icache_pkg::tag_entry_s [icache_pkg::num_ways-1:0] entries_tl;
  icache_pkg::tag_entry_s [icache_pkg::num_ways-1:0] entries_tv_r;
  logic [icache_pkg::num_ways-1:0][icache_pkg::bank_width-1:0] bank_rdata;
  logic [icache_pkg::num_ways-1:0][icache_pkg::bank_width-1:0] bank_rdata_tv_r;

  icache_pkg::bank_addr_t [icache_pkg::num_ways-1:0] bank_addr;
  logic [icache_pkg::num_ways-1:0] bank_we;
  logic [icache_pkg::num_ways-1:0][icache_pkg::bank_width-1:0] bank_wdata;

  logic [icache_pkg::num_ways-1:0] valid_ways_tv;
  logic [icache_pkg::way_bits-1:0] hit_way_tv;
  logic [icache_pkg::way_bits-1:0] repl_way;

  assign vaddr_index =
    vaddr_i[icache_pkg::byte_bits+icache_pkg::word_bits +: icache_pkg::index_bits];
  assign vaddr_word = vaddr_i[icache_pkg::byte_bits +: icache_pkg::word_bits];

  // TL stage
  assign vaddr_ready_o = cache_req_ready_i & ~miss_r & ~cache_req_v_o;
  assign tl_we = vaddr_v_i & vaddr_ready_o;

  // fetch has priority over both fill ports
  assign tag_pkt_ready_o = ~tl_we;
  assign data_pkt_ready_o = ~tl_we;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      v_tl_r <= 1'b0;
    end else begin
      v_tl_r <= tl_we;
    end
  end

  always_ff @(posedge clk_i) begin
    if (tl_we) begin
      poff_tl_r <= vaddr_i[icache_pkg::page_offset_bits-1:0];
    end
  end

  // TV stage; a miss drops the fetch behind it and waits for request ready
  assign miss_tv = v_tv_r & ~hit_tv;
  assign tv_hold = miss_tv & ~cache_req_ready_i;
  assign tv_we = v_tl_r & ptag_v_i & ~miss_tv;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      v_tv_r <= 1'b0;
    end else if (!tv_hold) begin
      v_tv_r <= tv_we;
    end
  end

  always_ff @(posedge clk_i) begin
    if (tv_we) begin
      paddr_tv_r <= {ptag_i, poff_tl_r};
      entries_tv_r <= entries_tl;
      bank_rdata_tv_r <= bank_rdata;
    end
  end

  assign index_tv =
    paddr_tv_r[icache_pkg::byte_bits+icache_pkg::word_bits +: icache_pkg::index_bits];

  always_comb begin
    for (int w = 0; w < icache_pkg::num_ways; w++) begin
      valid_ways_tv[w] = entries_tv_r[w].state != icache_pkg::coh_invalid;
    end
  end

  assign data_v_o = v_tv_r & hit_tv;
  assign cache_req_v_o = miss_tv & cache_req_ready_i;

  // block-aligned miss address
  always_comb begin
    cache_req_o.req_type = icache_pkg::req_miss_load;
    cache_req_o.addr =
      {paddr_tv_r[icache_pkg::paddr_width-1:icache_pkg::byte_bits+icache_pkg::word_bits],
       {(icache_pkg::byte_bits+icache_pkg::word_bits){1'b0}}};
    cache_req_o.repl_way = repl_way;
  end

  // miss tracker
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      miss_r <= 1'b0;
    end else if (cache_req_v_o) begin
      miss_r <= 1'b1;
    end else if (cache_req_complete_i) begin
      miss_r <= 1'b0;
    end
  end

  assign miss_o = miss_r;

  icache_fill_steer fill_steer (
    .fetch_v_i    (tl_we),
    .fetch_addr_i ({vaddr_index, vaddr_word}),
    .data_pkt_v_i (data_pkt_v_i),
    .data_pkt_i   (data_pkt_i),
    .bank_addr_o  (bank_addr),
    .bank_we_o    (bank_we),
    .bank_wdata_o (bank_wdata)
  );

  for (genvar b = 0; b < icache_pkg::num_ways; b++) begin : g_bank
    icache_data_bank data_bank (
      .clk_i   (clk_i),
      .addr_i  (bank_addr[b]),
      .we_i    (bank_we[b]),
      .wdata_i (bank_wdata[b]),
      .rdata_o (bank_rdata[b])
    );
  end

  icache_tag_array tag_array (
    .clk_i       (clk_i),
    .reset_i     (reset_i),
    .rd_v_i      (tl_we),
    .rd_index_i  (vaddr_index),
    .tag_pkt_v_i (tag_pkt_v_i & tag_pkt_ready_o),
    .tag_pkt_i   (tag_pkt_i),
    .entries_o   (entries_tl)
  );

  icache_way_select way_select (
    .entries_i    (entries_tv_r),
    .ptag_i       (paddr_tv_r[icache_pkg::page_offset_bits +: icache_pkg::ptag_width]),
    .word_i       (paddr_tv_r[icache_pkg::byte_bits +: icache_pkg::word_bits]),
    .half_i       (paddr_tv_r[icache_pkg::byte_bits-1]),
    .bank_rdata_i (bank_rdata_tv_r),
    .hit_o        (hit_tv),
    .hit_way_o    (hit_way_tv),
    .instr_o      (data_o)
  );

  icache_lru lru (
    .clk_i        (clk_i),
    .reset_i      (reset_i),
    .update_v_i   (data_v_o),
    .index_i      (index_tv),
    .hit_way_i    (hit_way_tv),
    .valid_ways_i (valid_ways_tv),
    .repl_way_o   (repl_way)
  );

  // one request cycle per missing fetch
  assert property (@(posedge clk_i) disable iff (reset_i) cache_req_v_o |=> !cache_req_v_o)
    else $error("miss request held for more than one cycle");

  // a pending miss flushes TL and TV, so nothing may return until it completes
  assert property (@(posedge clk_i) disable iff (reset_i) data_v_o |-> !miss_o)
    else $error("instruction returned while a miss is pending");

endmodule

// ==== icache_way_select.sv ====
// icache TV hit logic: tag compare, hit way encode, bank pick and instruction half select
module icache_way_select (
  input  icache_pkg::tag_entry_s [icache_pkg::num_ways-1:0] entries_i,
  input  logic [icache_pkg::ptag_width-1:0]      ptag_i,
  input  logic [icache_pkg::word_bits-1:0]       word_i,
  input  logic                                   half_i,
  input  logic [icache_pkg::num_ways-1:0][icache_pkg::bank_width-1:0] bank_rdata_i,
  output logic                                   hit_o,
  output logic [icache_pkg::way_bits-1:0]        hit_way_o,
  output logic [icache_pkg::instr_width-1:0]     instr_o
);

  logic [icache_pkg::num_ways-1:0] match;
  logic [icache_pkg::bank_width-1:0] word_picked;

  always_comb begin
    for (int w = 0; w < icache_pkg::num_ways; w++) begin
      match[w] = (entries_i[w].state != icache_pkg::coh_invalid)
                 && (entries_i[w].tag == ptag_i);
    end
  end

  // lowest matching way wins
  always_comb begin
    hit_o = 1'b0;
    hit_way_o = '0;
    for (int w = icache_pkg::num_ways - 1; w >= 0; w--) begin
      if (match[w]) begin
        hit_o = 1'b1;
        hit_way_o = (icache_pkg::way_bits)'(w);
      end
    end
  end

  // word w of way h sits in bank h ^ w
  assign word_picked = bank_rdata_i[hit_way_o ^ word_i];

  assign instr_o = half_i ? word_picked[icache_pkg::instr_width +: icache_pkg::instr_width]
                          : word_picked[icache_pkg::instr_width-1:0];

  // fills never place one block in two ways of a set
  always_comb begin
    assert ($onehot0(match))
      else $error("tag hit in more than one way of a set");
  end

endmodule

// ==== run.sh ====
#!/bin/sh
verilator --binary --timing --assert --top-module tb_icache -f sim.f -o tb_icache_sim \
  > build.log 2>&1 || { cat build.log; echo "verilator build failed"; exit 1; }
./obj_dir/tb_icache_sim > sim.log 2>&1
status=$?
cat sim.log
grep -q ">>> FAIL" sim.log && { echo "simulation reported failure"; exit 1; }
[ "$status" -eq 0 ] || { echo "simulator exited with status $status"; exit 1; }
echo "simulation passed"

// ==== sim.f ====
icache_pkg.sv
icache_data_bank.sv
icache_fill_steer.sv
icache_tag_array.sv
icache_way_select.sv
icache_lru.sv
icache_top.sv
tb_icache.sv

// ==== tb_icache.sv ====
// icache testbench: drives fetches, fills and misses through icache_top and checks against a model
module tb_icache;

  logic clk_i;
  logic reset_i;
  logic [icache_pkg::vaddr_width-1:0] vaddr_i;
  logic vaddr_v_i;
  logic vaddr_ready_o;
  logic [icache_pkg::ptag_width-1:0] ptag_i;
  logic ptag_v_i;
  logic [icache_pkg::instr_width-1:0] data_o;
  logic data_v_o;
  logic miss_o;
  icache_pkg::cache_req_s cache_req_o;
  logic cache_req_v_o;
  logic cache_req_ready_i;
  logic cache_req_complete_i;
  icache_pkg::tag_pkt_s tag_pkt_i;
  logic tag_pkt_v_i;
  logic tag_pkt_ready_o;
  icache_pkg::data_pkt_s data_pkt_i;
  logic data_pkt_v_i;
  logic data_pkt_ready_o;

  // reference model of the cache contents
  logic [19:0] model_tag [16][4];
  logic model_valid [16][4];
  logic [255:0] model_data [16][4];
  logic [2:0] model_lru [16];

  logic exp_miss;
  logic [31:0] exp_instr;
  logic [31:0] exp_addr;
  logic [1:0] exp_repl;

  integer seed;
  int mismatch_count;
  int timeout_count;
  int max_wait;
  logic [31:0] r;

  icache_top uut (
    .clk_i(clk_i), .reset_i(reset_i),
    .vaddr_i(vaddr_i), .vaddr_v_i(vaddr_v_i), .vaddr_ready_o(vaddr_ready_o),
    .ptag_i(ptag_i), .ptag_v_i(ptag_v_i),
    .data_o(data_o), .data_v_o(data_v_o), .miss_o(miss_o),
    .cache_req_o(cache_req_o), .cache_req_v_o(cache_req_v_o),
    .cache_req_ready_i(cache_req_ready_i), .cache_req_complete_i(cache_req_complete_i),
    .tag_pkt_i(tag_pkt_i), .tag_pkt_v_i(tag_pkt_v_i), .tag_pkt_ready_o(tag_pkt_ready_o),
    .data_pkt_i(data_pkt_i), .data_pkt_v_i(data_pkt_v_i), .data_pkt_ready_o(data_pkt_ready_o)
  );

  initial begin
    clk_i = 1'b0;
    forever #20 clk_i = ~clk_i;
  end

  assert property (@(posedge clk_i) disable iff (reset_i)
    data_v_o |-> (!exp_miss && data_o == exp_instr))
    else begin
      mismatch_count = mismatch_count + 1;
      $display("MISMATCH at %0t: hit returned %h, model expects miss=%0d instr %h",
               $time, data_o, exp_miss, exp_instr);
    end

  assert property (@(posedge clk_i) disable iff (reset_i)
    cache_req_v_o |-> (exp_miss && cache_req_o.addr == exp_addr
                       && cache_req_o.repl_way == exp_repl
                       && cache_req_o.req_type == icache_pkg::req_miss_load))
    else begin
      mismatch_count = mismatch_count + 1;
      $display("MISMATCH at %0t: request addr %h way %0d, model expects miss=%0d addr %h way %0d",
               $time, cache_req_o.addr, cache_req_o.repl_way, exp_miss, exp_addr, exp_repl);
    end

  // a pending miss blocks fetch and returns nothing
  assert property (@(posedge clk_i) disable iff (reset_i) miss_o |-> (!data_v_o && !vaddr_ready_o))
    else begin
      mismatch_count = mismatch_count + 1;
      $display("MISMATCH at %0t: fetch ready or data valid while a miss is pending", $time);
    end

  assert property (@(posedge clk_i) disable iff (reset_i)
    !cache_req_ready_i |-> (!vaddr_ready_o && !cache_req_v_o))
    else begin
      mismatch_count = mismatch_count + 1;
      $display("MISMATCH at %0t: fetch ready or request valid without request ready", $time);
    end

  assert property (@(posedge clk_i) disable iff (reset_i)
    $past(cache_req_v_o) |-> miss_o)
    else begin
      mismatch_count = mismatch_count + 1;
      $display("MISMATCH at %0t: miss_o did not rise after the request", $time);
    end

  assert property (@(posedge clk_i) disable iff (reset_i)
    cache_req_complete_i |-> miss_o)
    else begin
      mismatch_count = mismatch_count + 1;
      $display("MISMATCH at %0t: miss_o dropped before the completion", $time);
    end

  assert property (@(posedge clk_i) disable iff (reset_i)
    $past(cache_req_complete_i) |-> !miss_o)
    else begin
      mismatch_count = mismatch_count + 1;
      $display("MISMATCH at %0t: miss_o still high after the completion", $time);
    end

  assert property (@(posedge clk_i) disable iff (reset_i)
    (tag_pkt_ready_o == !(vaddr_v_i && vaddr_ready_o)) && (data_pkt_ready_o == tag_pkt_ready_o))
    else begin
      mismatch_count = mismatch_count + 1;
      $display("MISMATCH at %0t: packet ready does not yield to an accepted fetch", $time);
    end

  function automatic logic [11:0] page_off(input logic [3:0] index, input logic [1:0] word,
                                           input logic half);
    return {3'b000, index, word, half, 2'b00};
  endfunction

  // lowest invalid way, else follow the tree bits
  function automatic logic [1:0] lru_victim(input logic [3:0] index);
    logic [1:0] way;
    if (model_lru[index][0]) begin
      way = model_lru[index][2] ? 2'd3 : 2'd2;
    end else begin
      way = model_lru[index][1] ? 2'd1 : 2'd0;
    end
    for (int w = 3; w >= 0; w--) begin
      if (!model_valid[index][w]) begin
        way = 2'(w);
      end
    end
    return way;
  endfunction

  task automatic predict(input logic [19:0] ptag, input logic [11:0] poff);
    logic [3:0] index;
    int hit_way;
    int bit_pos;
    index = poff[8:5];
    hit_way = -1;
    for (int w = 3; w >= 0; w--) begin
      if (model_valid[index][w] && model_tag[index][w] == ptag) begin
        hit_way = w;
      end
    end
    exp_addr = {ptag, poff[11:5], 5'b00000};
    exp_miss = (hit_way < 0);
    if (exp_miss) begin
      exp_repl = lru_victim(index);
    end else begin
      bit_pos = int'(poff[4:3]) * 64 + int'(poff[2]) * 32;
      exp_instr = model_data[index][hit_way][bit_pos +: 32];
      // root points at the other pair, pair bit at the other way
      model_lru[index][0] = (hit_way < 2);
      if (hit_way < 2) begin
        model_lru[index][1] = (hit_way % 2 == 0);
      end else begin
        model_lru[index][2] = (hit_way % 2 == 0);
      end
    end
  endtask

  // what: 0 fetch ready, 1 tag ready, 2 data ready, 3 response, 4 miss clear
  task automatic wait_for(input int what, input string event_name);
    logic seen;
    int cycles;
    seen = 1'b0;
    cycles = 0;
    while (!seen && cycles < max_wait) begin
      @(negedge clk_i);
      case (what)
        0: seen = vaddr_ready_o;
        1: seen = tag_pkt_ready_o;
        2: seen = data_pkt_ready_o;
        3: seen = data_v_o | cache_req_v_o;
        default: seen = !miss_o;
      endcase
      @(posedge clk_i);
      #2;
      cycles++;
    end
    if (!seen) begin
      timeout_count++;
      $display("timeout at %0t: %s never arrived", $time, event_name);
    end
  endtask

  task automatic send_tag_pkt(input icache_pkg::tag_op_e op, input logic [3:0] index,
                              input logic [1:0] way, input logic [19:0] tag);
    tag_pkt_i.op = op;
    tag_pkt_i.index = index;
    tag_pkt_i.way_id = way;
    tag_pkt_i.tag = tag;
    tag_pkt_i.state = (op == icache_pkg::tag_set_tag) ? icache_pkg::coh_shared
                                                      : icache_pkg::coh_invalid;
    tag_pkt_v_i = 1'b1;
    wait_for(1, "tag packet acceptance");
    tag_pkt_v_i = 1'b0;
    for (int w = 0; w < 4; w++) begin
      if (op == icache_pkg::tag_set_clear) begin
        model_valid[index][w] = 1'b0;
        model_tag[index][w] = '0;
      end
    end
    if (op == icache_pkg::tag_invalidate) begin
      model_valid[index][way] = 1'b0;
    end
    if (op == icache_pkg::tag_set_tag) begin
      model_valid[index][way] = 1'b1;
      model_tag[index][way] = tag;
    end
  endtask

  task automatic fill_block(input logic [19:0] ptag, input logic [3:0] index,
                            input logic [1:0] way);
    logic [255:0] block;
    for (int i = 0; i < 8; i++) begin
      r = $random(seed);
      block[i*32 +: 32] = r;
    end
    send_tag_pkt(icache_pkg::tag_set_tag, index, way, ptag);
    data_pkt_i.index = index;
    data_pkt_i.way_id = way;
    data_pkt_i.data = block;
    data_pkt_v_i = 1'b1;
    wait_for(2, "data packet acceptance");
    data_pkt_v_i = 1'b0;
    model_data[index][way] = block;
  endtask

  task automatic complete_miss();
    repeat (3) begin
      @(posedge clk_i);
      #2;
    end
    cache_req_complete_i = 1'b1;
    @(posedge clk_i);
    #2;
    cache_req_complete_i = 1'b0;
    wait_for(4, "miss clear after completion");
  endtask

  // hold keeps request ready low for that many cycles from the TL cycle on
  task automatic fetch(input logic [19:0] ptag, input logic [11:0] poff, input int hold);
    predict(ptag, poff);
    r = $random(seed);
    // virtual page differs from the physical tag
    vaddr_i = {r[31:12], poff};
    vaddr_v_i = 1'b1;
    wait_for(0, "fetch acceptance");
    vaddr_v_i = 1'b0;
    ptag_i = ptag;
    ptag_v_i = 1'b1;
    if (hold > 0) begin
      cache_req_ready_i = 1'b0;
    end
    @(posedge clk_i);
    #2;
    ptag_v_i = 1'b0;
    repeat (hold) begin
      @(posedge clk_i);
      #2;
    end
    cache_req_ready_i = 1'b1;
    wait_for(3, "hit or miss response");
    if (exp_miss) begin
      fill_block(ptag, poff[8:5], exp_repl);
    end
    if (exp_miss || miss_o) begin
      complete_miss();
    end
  endtask

  initial begin
    seed = 4521;
    mismatch_count = 0;
    timeout_count = 0;
    max_wait = 50;
    reset_i = 1'b1;
    vaddr_i = '0;
    vaddr_v_i = 1'b0;
    ptag_i = '0;
    ptag_v_i = 1'b0;
    cache_req_ready_i = 1'b1;
    cache_req_complete_i = 1'b0;
    tag_pkt_i = '0;
    tag_pkt_v_i = 1'b0;
    data_pkt_i = '0;
    data_pkt_v_i = 1'b0;
    for (int s = 0; s < 16; s++) begin
      model_lru[s] = 3'b000;
    end
    repeat (3) @(posedge clk_i);
    #2;
    reset_i = 1'b0;

    for (int s = 0; s < 16; s++) begin
      send_tag_pkt(icache_pkg::tag_set_clear, 4'(s), 2'd0, '0);
    end

    // cold miss into way 0, then every instruction of the block
    fetch(20'h12345, page_off(4'd3, 2'd2, 1'b1), 0);
    for (int w = 0; w < 4; w++) begin
      for (int h = 0; h < 2; h++) begin
        fetch(20'h12345, page_off(4'd3, 2'(w), 1'(h)), 0);
      end
    end

    // fill set 9, mix hits, then evict by the tree
    for (int k = 0; k < 4; k++) begin
      fetch(20'ha0000 + 20'(k), page_off(4'd9, 2'd0, 1'b0), 0);
    end
    for (int i = 0; i < 8; i++) begin
      r = $random(seed);
      fetch(20'ha0000 + {18'd0, r[1:0]}, page_off(4'd9, r[3:2], r[4]), 0);
    end
    fetch(20'ha0004, page_off(4'd9, 2'd1, 1'b0), 0);

    send_tag_pkt(icache_pkg::tag_invalidate, 4'd9, 2'd1, '0);
    fetch(model_tag[9][1], page_off(4'd9, 2'd3, 1'b1), 0);

    // request ready held low across the miss
    fetch(20'h55555, page_off(4'd12, 2'd1, 1'b0), 4);
    fetch(20'h55555, page_off(4'd12, 2'd1, 1'b1), 0);

    $display("summary: %0d mismatches, %0d timeouts", mismatch_count, timeout_count);
    if (mismatch_count == 0 && timeout_count == 0) begin
      $display(">>> PASS");
    end else begin
      $display(">>> FAIL");
    end
    $finish;
  end

endmodule
